// ==== design/rfu_cfg.svh ====
// register file unit sizing, shared by the package and every module
// bank depth must stay 2**RFU_ADDR_W and data width a multiple of 8
`ifndef RFU_CFG_SVH
`define RFU_CFG_SVH

// --------------------
// word and index
// --------------------
`define RFU_DATA_W    32
`define RFU_ADDR_W    5
`define RFU_DEPTH     32
`define RFU_BEN_W     4

// --------------------
// port and bank counts
// --------------------
`define RFU_NUM_RD    4
`define RFU_NUM_BANKS 2

`endif

// ==== design/rfu_pkg.sv ====
// request and response types for the register file unit
// bank index 0 is A and 1 is B in every two-bit per-bank field
`default_nettype none
`include "rfu_cfg.svh"

package rfu_pkg;

    typedef logic [`RFU_ADDR_W-1:0] reg_addr_t;
    typedef logic [`RFU_DATA_W-1:0] reg_data_t;

    // --------------------
    // requests
    // --------------------
    typedef struct packed {
        logic      ena;
        reg_addr_t addr;
        logic      bank;
        logic      mode;
        reg_data_t const_val;
    } rd_req_t;

    typedef struct packed {
        reg_addr_t                 addr;
        logic [`RFU_NUM_BANKS-1:0] ena;
    } ry_req_t;

    // one bank's share of a writeback
    typedef struct packed {
        logic                  data_we;
        logic                  tag_we;
        logic [`RFU_BEN_W-1:0] ben;
        reg_data_t             data;
        logic                  tag;
    } lane_wr_t;

    typedef struct packed {
        reg_addr_t addr;
        lane_wr_t  lane_a;
        lane_wr_t  lane_b;
    } wr_port_t;

    // lock controller, ena_g flags a lock still in flight
    typedef struct packed {
        logic [`RFU_NUM_BANKS-1:0] ena_g;
        logic [`RFU_NUM_BANKS-1:0] ena_t0;
        logic [`RFU_NUM_BANKS-1:0] ena_t1;
        reg_addr_t                 addr;
        logic [`RFU_NUM_BANKS-1:0] tag;
    } lc_req_t;

    // --------------------
    // responses
    // --------------------
    typedef struct packed {
        reg_data_t data_a;
        reg_data_t data_b;
        logic      tagx_a;
        logic      tagy_a;
        logic      tagx_b;
        logic      tagy_b;
    } bank_rd_t;

    typedef struct packed {
        reg_data_t data;
        logic      locked;
    } rd_rsp_t;

    typedef struct packed {
        logic [`RFU_NUM_BANKS-1:0] ena;
        reg_addr_t                 addr;
        logic [`RFU_NUM_BANKS-1:0] tag;
        logic [`RFU_NUM_BANKS-1:0] locked;
    } ry_rsp_t;

endpackage

`default_nettype wire

// ==== design/rfu_data_bank.sv ====
// register data storage, no reset so contents are unknown until written
// reads are combinational and return the old word during a write
`default_nettype none
`timescale 1ns/1ps
`include "rfu_cfg.svh"

module rfu_data_bank
    import rfu_pkg::*;
#(
    parameter int N_RD = 4
)
(
    input  wire                   clk,
    input  wire                   i_we,
    input  wire  [`RFU_BEN_W-1:0] i_ben,
    input  reg_addr_t             i_waddr,
    input  reg_data_t             i_wdata,
    input  reg_addr_t             i_raddr [N_RD],
    output reg_data_t             o_rdata [N_RD]
);

    reg_data_t mem [`RFU_DEPTH];

    // --------------------
    // byte-enabled write
    // --------------------
    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            for (int b = 0; b < `RFU_BEN_W; b++)
            begin
                if (i_ben[b])
                    mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
            end
        end
    end

    // read ports
    always_comb
    begin
        for (int p = 0; p < N_RD; p++)
        begin
            o_rdata[p] = mem[i_raddr[p]];
        end
    end

endmodule

`default_nettype wire

// ==== design/rfu_tag_bank.sv ====
// one scoreboard bit per register, cleared by the asynchronous reset
// reads are combinational and return the old bit during a write
`default_nettype none
`timescale 1ns/1ps
`include "rfu_cfg.svh"

module rfu_tag_bank
    import rfu_pkg::*;
#(
    parameter int N_RD = 4
)
(
    input  wire       clk,
    input  wire       rst,
    input  wire       i_we,
    input  reg_addr_t i_waddr,
    input  wire       i_wtag,
    input  reg_addr_t i_raddr [N_RD],
    output logic      o_rtag  [N_RD]
);

    logic [`RFU_DEPTH-1:0] tags;

    // all tags start equal so nothing is pending
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            tags <= '0;
        else if (i_we)
            tags[i_waddr] <= i_wtag;
    end

    always_comb
    begin
        for (int p = 0; p < N_RD; p++)
        begin
            o_rtag[p] = tags[i_raddr[p]];
        end
    end

endmodule

`default_nettype wire

// ==== design/rfu_thread_file.sv ====
// banks A and B of one thread with their writeback and lock tags
// last read address is the Ry lookup, its data fields carry no meaning
`default_nettype none
`timescale 1ns/1ps
`include "rfu_cfg.svh"

module rfu_thread_file
    import rfu_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wr_port_t                  i_wr,
    input  reg_addr_t                 i_lc_addr,
    input  wire  [`RFU_NUM_BANKS-1:0] i_lc_we,
    input  wire  [`RFU_NUM_BANKS-1:0] i_lc_tag,
    input  reg_addr_t                 i_raddr [`RFU_NUM_RD+1],
    output bank_rd_t                  o_rd    [`RFU_NUM_RD+1]
);

    localparam int N_PORT = `RFU_NUM_RD + 1;

    reg_data_t data_a [N_PORT];
    reg_data_t data_b [N_PORT];
    logic      tagx_a [N_PORT];
    logic      tagy_a [N_PORT];
    logic      tagx_b [N_PORT];
    logic      tagy_b [N_PORT];

    // --------------------
    // data banks
    // --------------------
    rfu_data_bank #(.N_RD(N_PORT)) u_data_a (
        .clk     (clk),
        .i_we    (i_wr.lane_a.data_we),
        .i_ben   (i_wr.lane_a.ben),
        .i_waddr (i_wr.addr),
        .i_wdata (i_wr.lane_a.data),
        .i_raddr (i_raddr),
        .o_rdata (data_a)
    );

    rfu_data_bank #(.N_RD(N_PORT)) u_data_b (
        .clk     (clk),
        .i_we    (i_wr.lane_b.data_we),
        .i_ben   (i_wr.lane_b.ben),
        .i_waddr (i_wr.addr),
        .i_wdata (i_wr.lane_b.data),
        .i_raddr (i_raddr),
        .o_rdata (data_b)
    );

    // --------------------
    // tags, x from writeback and y from the lock controller
    // --------------------
    rfu_tag_bank #(.N_RD(N_PORT)) u_tagx_a (
        .clk(clk), .rst(rst), .i_we(i_wr.lane_a.tag_we), .i_waddr(i_wr.addr),
        .i_wtag(i_wr.lane_a.tag), .i_raddr(i_raddr), .o_rtag(tagx_a)
    );

    rfu_tag_bank #(.N_RD(N_PORT)) u_tagy_a (
        .clk(clk), .rst(rst), .i_we(i_lc_we[0]), .i_waddr(i_lc_addr),
        .i_wtag(i_lc_tag[0]), .i_raddr(i_raddr), .o_rtag(tagy_a)
    );

    rfu_tag_bank #(.N_RD(N_PORT)) u_tagx_b (
        .clk(clk), .rst(rst), .i_we(i_wr.lane_b.tag_we), .i_waddr(i_wr.addr),
        .i_wtag(i_wr.lane_b.tag), .i_raddr(i_raddr), .o_rtag(tagx_b)
    );

    rfu_tag_bank #(.N_RD(N_PORT)) u_tagy_b (
        .clk(clk), .rst(rst), .i_we(i_lc_we[1]), .i_waddr(i_lc_addr),
        .i_wtag(i_lc_tag[1]), .i_raddr(i_raddr), .o_rtag(tagy_b)
    );

    // pack per address
    always_comb
    begin
        for (int p = 0; p < N_PORT; p++)
        begin
            o_rd[p].data_a = data_a[p];
            o_rd[p].data_b = data_b[p];
            o_rd[p].tagx_a = tagx_a[p];
            o_rd[p].tagy_a = tagy_a[p];
            o_rd[p].tagx_b = tagx_b[p];
            o_rd[p].tagy_b = tagy_b[p];
        end
    end

endmodule

`default_nettype wire

// ==== design/rfu_read_stage.sv ====
// thread, bank and constant select with lock evaluation, one register stage
// an ena_g match locks a read even when the stored tags agree
`default_nettype none
`timescale 1ns/1ps
`include "rfu_cfg.svh"

module rfu_read_stage
    import rfu_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       i_tid,
    input  rd_req_t                   i_rd  [`RFU_NUM_RD],
    input  ry_req_t                   i_ry,
    input  wire  [`RFU_NUM_BANKS-1:0] i_lc_ena_g,
    input  reg_addr_t                 i_lc_addr,
    input  bank_rd_t                  i_th0 [`RFU_NUM_RD+1],
    input  bank_rd_t                  i_th1 [`RFU_NUM_RD+1],
    output rd_rsp_t                   o_rd  [`RFU_NUM_RD],
    output ry_rsp_t                   o_ry
);

    localparam int NRD = `RFU_NUM_RD;

    bank_rd_t  sel      [NRD+1];
    reg_addr_t port_addr[NRD+1];
    logic      hit_a    [NRD+1];
    logic      hit_b    [NRD+1];
    rd_rsp_t   rd_nxt   [NRD];
    ry_rsp_t   ry_nxt;

    // --------------------
    // thread select and lock conditions
    // --------------------
    always_comb
    begin
        for (int p = 0; p < NRD; p++)
        begin
            port_addr[p] = i_rd[p].addr;
        end
        port_addr[NRD] = i_ry.addr;

        for (int p = 0; p <= NRD; p++)
        begin
            sel[p]   = i_tid ? i_th1[p] : i_th0[p];
            // in-flight lock or pending register
            hit_a[p] = (i_lc_ena_g[0] && (port_addr[p] == i_lc_addr))
                       || (sel[p].tagx_a ^ sel[p].tagy_a);
            hit_b[p] = (i_lc_ena_g[1] && (port_addr[p] == i_lc_addr))
                       || (sel[p].tagx_b ^ sel[p].tagy_b);
        end
    end

    // source ports
    always_comb
    begin
        for (int p = 0; p < NRD; p++)
        begin
            if (i_rd[p].mode)
            begin
                rd_nxt[p].data   = i_rd[p].const_val;
                rd_nxt[p].locked = 1'b0;
            end
            else
            begin
                rd_nxt[p].data   = i_rd[p].bank ? sel[p].data_b : sel[p].data_a;
                rd_nxt[p].locked = i_rd[p].ena & (i_rd[p].bank ? hit_b[p] : hit_a[p]);
            end
        end
    end

    // destination, next tag to issue is the inverse of tag y
    always_comb
    begin
        ry_nxt.ena    = i_ry.ena;
        ry_nxt.addr   = i_ry.addr;
        ry_nxt.tag    = {~sel[NRD].tagy_b, ~sel[NRD].tagy_a};
        ry_nxt.locked = i_ry.ena & {hit_b[NRD], hit_a[NRD]};
    end

    // --------------------
    // output registers
    // --------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int p = 0; p < NRD; p++)
            begin
                o_rd[p] <= '0;
            end
            o_ry <= '0;
        end
        else
        begin
            for (int p = 0; p < NRD; p++)
            begin
                o_rd[p] <= rd_nxt[p];
            end
            o_ry <= ry_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== design/rfu_box.sv ====
// register file unit top, two threads sharing the read ports
// results arrive one cycle after the request, a same-cycle write is not seen
`default_nettype none
`timescale 1ns/1ps
`include "rfu_cfg.svh"

module rfu_box
    import rfu_pkg::*;
(
    input  wire      clk,
    input  wire      rst,
    input  wire      i_tid,
    input  rd_req_t  i_rd [`RFU_NUM_RD],
    input  ry_req_t  i_ry,
    input  wr_port_t i_wr0,
    input  wr_port_t i_wr1,
    input  lc_req_t  i_lc,
    output rd_rsp_t  o_rd [`RFU_NUM_RD],
    output ry_rsp_t  o_ry
);

    reg_addr_t raddr  [`RFU_NUM_RD+1];
    bank_rd_t  th0_rd [`RFU_NUM_RD+1];
    bank_rd_t  th1_rd [`RFU_NUM_RD+1];

    // source addresses then Ry
    always_comb
    begin
        for (int p = 0; p < `RFU_NUM_RD; p++)
        begin
            raddr[p] = i_rd[p].addr;
        end
        raddr[`RFU_NUM_RD] = i_ry.addr;
    end

    // --------------------
    // thread files
    // --------------------
    rfu_thread_file u_th0 (
        .clk(clk), .rst(rst), .i_wr(i_wr0), .i_lc_addr(i_lc.addr),
        .i_lc_we(i_lc.ena_t0), .i_lc_tag(i_lc.tag), .i_raddr(raddr), .o_rd(th0_rd)
    );

    rfu_thread_file u_th1 (
        .clk(clk), .rst(rst), .i_wr(i_wr1), .i_lc_addr(i_lc.addr),
        .i_lc_we(i_lc.ena_t1), .i_lc_tag(i_lc.tag), .i_raddr(raddr), .o_rd(th1_rd)
    );

    rfu_read_stage u_read_stage (
        .clk(clk), .rst(rst), .i_tid(i_tid), .i_rd(i_rd), .i_ry(i_ry),
        .i_lc_ena_g(i_lc.ena_g), .i_lc_addr(i_lc.addr),
        .i_th0(th0_rd), .i_th1(th1_rd), .o_rd(o_rd), .o_ry(o_ry)
    );

endmodule

`default_nettype wire

// ==== verification/rfu_tb.sv ====
// testbench for rfu_box with inputs changed on the falling edge
// model predicts each cycle's result, checked one rising edge later
// bank data is read only after every register has been written once
`default_nettype none
`timescale 1ns/1ps
`include "rfu_cfg.svh"

module rfu_tb
    import rfu_pkg::*;
();

    localparam int RST_CYCLES   = 2;
    localparam int FILL_CYCLES  = `RFU_DEPTH;
    localparam int RAND_CYCLES  = 400;
    localparam int LOCK_CYCLES  = 4 * 6;
    localparam int STIM_CYCLES  = RST_CYCLES + 1 + FILL_CYCLES + RAND_CYCLES + LOCK_CYCLES + 3;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic     clk = 1'b0;
    logic     rst;
    logic     i_tid;
    rd_req_t  i_rd [`RFU_NUM_RD];
    ry_req_t  i_ry;
    wr_port_t i_wr0;
    wr_port_t i_wr1;
    lc_req_t  i_lc;
    rd_rsp_t  o_rd [`RFU_NUM_RD];
    ry_rsp_t  o_ry;

    // reference model indexed by thread, bank and register
    reg_data_t m_data [2][2][`RFU_DEPTH];
    logic      m_tagx [2][2][`RFU_DEPTH];
    logic      m_tagy [2][2][`RFU_DEPTH];

    rd_rsp_t     exp_rd_nxt [`RFU_NUM_RD];
    rd_rsp_t     exp_rd_q   [`RFU_NUM_RD];
    ry_rsp_t     exp_ry_nxt;
    ry_rsp_t     exp_ry_q;
    logic [31:0] lcg_state = 32'h69fa_74d9;
    int          cycle_cnt = 0;

    rfu_box u_rfu_box (
        .clk(clk), .rst(rst), .i_tid(i_tid), .i_rd(i_rd), .i_ry(i_ry),
        .i_wr0(i_wr0), .i_wr1(i_wr1), .i_lc(i_lc), .o_rd(o_rd), .o_ry(o_ry)
    );

    always #2 clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    // upper halves of two LCG steps since the low bits repeat too soon
    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic logic is_locked(input logic t, input logic b, input reg_addr_t a);
        return (m_tagx[t][b][a] != m_tagy[t][b][a])
               || (i_lc.ena_g[b] && (i_lc.addr == a));
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic idle_inputs();
        i_tid = 1'b0;
        for (int p = 0; p < `RFU_NUM_RD; p++)
        begin
            i_rd[p] = '0;
            i_rd[p].mode = 1'b1;
        end
        i_ry  = '0;
        i_wr0 = '0;
        i_wr1 = '0;
        i_lc  = '0;
    endtask

    task automatic start_cycle();
        @(negedge clk);
        idle_inputs();
    endtask

    task automatic set_read(input int p, input reg_addr_t a, input logic b);
        i_rd[p].ena  = 1'b1;
        i_rd[p].addr = a;
        i_rd[p].bank = b;
        i_rd[p].mode = 1'b0;
        i_ry.addr    = a;
        i_ry.ena     = 2'b11;
    endtask

    task automatic apply_writeback(input logic t, input wr_port_t w);
        lane_wr_t ln;
        for (int b = 0; b < 2; b++)
        begin
            ln = b ? w.lane_b : w.lane_a;
            if (ln.data_we)
            begin
                for (int k = 0; k < `RFU_BEN_W; k++)
                begin
                    if (ln.ben[k])
                        m_data[t][b][w.addr][k*8 +: 8] = ln.data[k*8 +: 8];
                end
            end
            if (ln.tag_we)
                m_tagx[t][b][w.addr] = ln.tag;
        end
    endtask

    // predict from the old state, then apply this cycle's writes
    task automatic model_step();
        for (int p = 0; p < `RFU_NUM_RD; p++)
        begin
            if (i_rd[p].mode)
            begin
                exp_rd_nxt[p].data   = i_rd[p].const_val;
                exp_rd_nxt[p].locked = 1'b0;
            end
            else
            begin
                exp_rd_nxt[p].data   = m_data[i_tid][i_rd[p].bank][i_rd[p].addr];
                exp_rd_nxt[p].locked = i_rd[p].ena
                                       && is_locked(i_tid, i_rd[p].bank, i_rd[p].addr);
            end
        end
        exp_ry_nxt.ena  = i_ry.ena;
        exp_ry_nxt.addr = i_ry.addr;
        for (int b = 0; b < 2; b++)
        begin
            exp_ry_nxt.tag[b]    = ~m_tagy[i_tid][b][i_ry.addr];
            exp_ry_nxt.locked[b] = i_ry.ena[b] && is_locked(i_tid, b[0], i_ry.addr);
        end
        apply_writeback(1'b0, i_wr0);
        apply_writeback(1'b1, i_wr1);
        for (int b = 0; b < 2; b++)
        begin
            if (i_lc.ena_t0[b])
                m_tagy[0][b][i_lc.addr] = i_lc.tag[b];
            if (i_lc.ena_t1[b])
                m_tagy[1][b][i_lc.addr] = i_lc.tag[b];
        end
    endtask

    // --------------------
    // stimulus sequences
    // --------------------
    task automatic random_wb(output wr_port_t w);
        logic [31:0] r;
        r = rand32();
        w.addr           = r[4:0];
        w.lane_a.data_we = r[5];
        w.lane_a.tag_we  = (r[8:6] == 3'd0);
        w.lane_a.ben     = r[12:9];
        w.lane_a.tag     = r[13];
        w.lane_b.data_we = r[14];
        w.lane_b.tag_we  = (r[17:15] == 3'd0);
        w.lane_b.ben     = r[21:18];
        w.lane_b.tag     = r[22];
        w.lane_a.data    = rand32();
        w.lane_b.data    = rand32();
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        start_cycle();
        r = rand32();
        i_tid     = r[0];
        i_ry.addr = r[5:1];
        i_ry.ena  = r[7:6];
        for (int p = 0; p < `RFU_NUM_RD; p++)
        begin
            r = rand32();
            i_rd[p].ena       = r[0];
            i_rd[p].addr      = r[5:1];
            i_rd[p].bank      = r[6];
            i_rd[p].mode      = (r[9:7] == 3'd0);
            i_rd[p].const_val = rand32();
        end
        random_wb(i_wr0);
        random_wb(i_wr1);
        r = rand32();
        i_lc.ena_g  = (r[2:0] == 3'd0) ? r[4:3] : 2'b00;
        i_lc.ena_t0 = (r[7:5] == 3'd0) ? r[9:8] : 2'b00;
        i_lc.ena_t1 = (r[12:10] == 3'd0) ? r[14:13] : 2'b00;
        i_lc.addr   = r[19:15];
        i_lc.tag    = r[21:20];
        model_step();
    endtask

    // lock one register, look from both threads, then release it
    task automatic lock_sequence(input logic t, input logic b, input reg_addr_t a);
        logic     new_y;
        wr_port_t w;
        start_cycle();
        new_y          = ~m_tagx[t][b][a];
        i_lc.addr      = a;
        i_lc.tag[b]    = new_y;
        i_lc.ena_t0[b] = ~t;
        i_lc.ena_t1[b] = t;
        model_step();
        // pending read with port 1 as a constant on the same register
        start_cycle();
        i_tid = t;
        set_read(0, a, b);
        i_rd[1].ena       = 1'b1;
        i_rd[1].addr      = a;
        i_rd[1].bank      = b;
        i_rd[1].const_val = rand32();
        model_step();
        start_cycle();
        i_tid = ~t;
        set_read(0, a, b);
        model_step();
        // tag x catches up
        start_cycle();
        w      = '0;
        w.addr = a;
        if (b)
        begin
            w.lane_b.tag_we = 1'b1;
            w.lane_b.tag    = new_y;
        end
        else
        begin
            w.lane_a.tag_we = 1'b1;
            w.lane_a.tag    = new_y;
        end
        if (t)
            i_wr1 = w;
        else
            i_wr0 = w;
        model_step();
        start_cycle();
        i_tid = t;
        set_read(0, a, b);
        model_step();
        // lock still in flight while the tags agree
        start_cycle();
        i_tid = t;
        set_read(0, a, b);
        i_lc.ena_g[b] = 1'b1;
        i_lc.addr     = a;
        model_step();
    endtask

    // --------------------
    // checks
    // --------------------
    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int p = 0; p < `RFU_NUM_RD; p++)
            begin
                exp_rd_q[p] <= '0;
            end
            exp_ry_q <= '0;
        end
        else
        begin
            for (int p = 0; p < `RFU_NUM_RD; p++)
            begin
                exp_rd_q[p] <= exp_rd_nxt[p];
            end
            exp_ry_q <= exp_ry_nxt;
        end
    end

    for (genvar p = 0; p < `RFU_NUM_RD; p++)
    begin : g_port_chk
        a_data: assert property (@(posedge clk) disable iff (rst)
            o_rd[p].data === exp_rd_q[p].data)
            else report_mismatch($sformatf("port %0d data got %h expected %h", p,
                $sampled(o_rd[p].data), $sampled(exp_rd_q[p].data)));
        a_locked: assert property (@(posedge clk) disable iff (rst)
            o_rd[p].locked === exp_rd_q[p].locked)
            else report_mismatch($sformatf("port %0d locked got %b expected %b", p,
                $sampled(o_rd[p].locked), $sampled(exp_rd_q[p].locked)));
    end

    a_ry: assert property (@(posedge clk) disable iff (rst) o_ry === exp_ry_q)
        else report_mismatch($sformatf("ry got %h expected %h",
            $sampled(o_ry), $sampled(exp_ry_q)));

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial
    begin
        logic [31:0] r;
        rst = 1'b1;
        idle_inputs();
        for (int t = 0; t < 2; t++)
        begin
            for (int b = 0; b < 2; b++)
            begin
                for (int a = 0; a < `RFU_DEPTH; a++)
                begin
                    m_tagx[t][b][a] = 1'b0;
                    m_tagy[t][b][a] = 1'b0;
                end
            end
        end
        repeat (RST_CYCLES) @(negedge clk);
        // first checked edge sees the reset values
        rst = 1'b0;
        model_step();

        // full-word fill of every register in both threads
        for (int a = 0; a < FILL_CYCLES; a++)
        begin
            start_cycle();
            i_wr0.addr = reg_addr_t'(a);
            i_wr1.addr = reg_addr_t'(a);
            i_wr0.lane_a = '{data_we: 1'b1, tag_we: 1'b0, ben: '1, data: rand32(), tag: 1'b0};
            i_wr0.lane_b = '{data_we: 1'b1, tag_we: 1'b0, ben: '1, data: rand32(), tag: 1'b0};
            i_wr1.lane_a = '{data_we: 1'b1, tag_we: 1'b0, ben: '1, data: rand32(), tag: 1'b0};
            i_wr1.lane_b = '{data_we: 1'b1, tag_we: 1'b0, ben: '1, data: rand32(), tag: 1'b0};
            model_step();
        end

        repeat (RAND_CYCLES) random_cycle();

        for (int t = 0; t < 2; t++)
        begin
            for (int b = 0; b < 2; b++)
            begin
                r = rand32();
                lock_sequence(t[0], b[0], r[4:0]);
            end
        end

        repeat (2)
        begin
            start_cycle();
            model_step();
        end
        @(posedge clk);
        @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/rfu_pkg.sv
design/rfu_data_bank.sv
design/rfu_tag_bank.sv
design/rfu_thread_file.sv
design/rfu_read_stage.sv
design/rfu_box.sv
verification/rfu_tb.sv

// ==== Bender.yml ====
package:
  name: rfu_box

export_include_dirs:
  - design

sources:
  - files:
      - design/rfu_pkg.sv
      - design/rfu_data_bank.sv
      - design/rfu_tag_bank.sv
      - design/rfu_thread_file.sv
      - design/rfu_read_stage.sv
      - design/rfu_box.sv
  - target: test
    files:
      - verification/rfu_tb.sv
